//--- hdl/vdec_pkg.sv
////////////////////////////////////////////////////////////
// shared encodings for the RVV decode stage
// integer OPI, OPM reductions, mul/div and mask logicals only
// no widening, fixed point, permute, unary or FP encodings
// vinstr_u overlays the arithmetic and memory formats
////////////////////////////////////////////////////////////
package vdec_pkg;

  localparam int INSTR_W   = 32;
  localparam int REG_IDX_W = 5;

  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_VECTOR   = 7'b1010111;

  // element widths accepted on the memory path
  localparam logic [2:0] VW_8  = 3'd0;
  localparam logic [2:0] VW_16 = 3'd5;
  localparam logic [2:0] VW_32 = 3'd6;

  localparam logic [1:0] MOP_STRIDED = 2'd2;

  // allowed operand forms as {vi, vx, vv}, OPM reuses vv/vx
  localparam logic [2:0] FM_VV_VX_VI = 3'b111;
  localparam logic [2:0] FM_VV_VX    = 3'b011;
  localparam logic [2:0] FM_VX_VI    = 3'b110;
  localparam logic [2:0] FM_VV       = 3'b001;

  typedef enum logic [2:0] {
    OPIVV = 3'd0, OPFVV = 3'd1, OPMVV = 3'd2, OPIVI = 3'd3,
    OPIVX = 3'd4, OPFVF = 3'd5, OPMVX = 3'd6, OPCFG = 3'd7
  } vfunct3_e;

  typedef enum logic [5:0] {
    VADD   = 6'b000000, VSUB   = 6'b000010, VRSUB  = 6'b000011, VMINU  = 6'b000100,
    VMIN   = 6'b000101, VMAXU  = 6'b000110, VMAX   = 6'b000111, VAND   = 6'b001001,
    VOR    = 6'b001010, VXOR   = 6'b001011, VADC   = 6'b010000, VMADC  = 6'b010001,
    VSBC   = 6'b010010, VMSBC  = 6'b010011, VMERGE = 6'b010111, VMSEQ  = 6'b011000,
    VMSNE  = 6'b011001, VMSLTU = 6'b011010, VMSLT  = 6'b011011, VMSLEU = 6'b011100,
    VMSLE  = 6'b011101, VMSGTU = 6'b011110, VMSGT  = 6'b011111, VSLL   = 6'b100101,
    VSRL   = 6'b101000, VSRA   = 6'b101001, VNSRL  = 6'b101100, VNSRA  = 6'b101101
  } vopi_f6_e;

  typedef enum logic [5:0] {
    VREDSUM = 6'b000000, VREDAND  = 6'b000001, VREDOR  = 6'b000010, VREDXOR = 6'b000011,
    VREDMINU = 6'b000100, VREDMIN = 6'b000101, VREDMAXU = 6'b000110, VREDMAX = 6'b000111,
    VMANDN  = 6'b011000, VMAND    = 6'b011001, VMOR    = 6'b011010, VMXOR   = 6'b011011,
    VMORN   = 6'b011100, VMNAND   = 6'b011101, VMNOR   = 6'b011110, VMXNOR  = 6'b011111,
    VDIVU   = 6'b100000, VDIV     = 6'b100001, VREMU   = 6'b100010, VREM    = 6'b100011,
    VMULHU  = 6'b100100, VMUL     = 6'b100101, VMULHSU = 6'b100110, VMULH   = 6'b100111
  } vopm_f6_e;

  // groups stay contiguous, vunit_select decodes by range
  typedef enum logic [5:0] {
    OP_NONE,
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR, OP_VADC, OP_VMADC, OP_VSBC, OP_VMSBC, OP_VMERGE,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT, OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA, OP_VNSRL, OP_VNSRA,
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX,
    OP_VMANDN, OP_VMAND, OP_VMOR, OP_VMXOR, OP_VMORN, OP_VMNAND, OP_VMNOR, OP_VMXNOR,
    OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM,
    OP_VMULHU, OP_VMUL, OP_VMULHSU, OP_VMULH
  } vop_e;

  typedef enum logic [2:0] {
    FU_ARITH, FU_RED, FU_MUL, FU_DIV, FU_MASK, FU_LDST
  } fu_e;

  typedef enum logic [3:0] {
    VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR, VALU_SLL,
    VALU_SRL, VALU_SRA, VALU_COMP, VALU_MERGE, VALU_MM
  } aluop_e;

  // same order as the compare block of vop_e
  typedef enum logic [2:0] {
    VSEQ, VSNE, VSLTU, VSLT, VSLEU, VSLE, VSGTU, VSGT
  } comp_e;

  typedef enum logic [1:0] {MIN, MINU, MAX, MAXU} minmax_e;

  typedef enum logic [2:0] {NORMAL, CARRY, MULT, DIV, REM} result_e;

  typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} cfgsel_e;

  typedef union packed {
    struct packed {
      logic [5:0] funct6;
      logic       vm;
      logic [4:0] vs2;
      logic [4:0] vs1;
      vfunct3_e   funct3;
      logic [4:0] vd;
      logic [6:0] opcode;
    } arith;
    struct packed {
      logic [2:0] nf;
      logic       mew;
      logic [1:0] mop;
      logic       vm;
      logic [4:0] rs2;    // lumop / sumop for unit stride
      logic [4:0] rs1;
      logic [2:0] width;
      logic [4:0] vd;     // vs3 on stores
      logic [6:0] opcode;
    } mem;
  } vinstr_u;

endpackage

//--- hdl/vfield_decode.sv
////////////////////////////////////////////////////////////
// field split and class decode, purely combinational
// memory words need an 8/16/32-bit width to count
// wen covers every OPI/OPM class word, legal funct6 or not
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module vfield_decode (
  input  vdec_pkg::vinstr_u              instr,
  output logic [vdec_pkg::REG_IDX_W-1:0] vs1, vs2, vd,
  output logic [2:0]                     nf, mem_width,
  output logic [1:0]                     mop,
  output logic                           vm, is_vload, is_vstore, is_vopi, is_vopm, imm_op,
  output logic                           rs1_scalar_src, rs2_scalar_src, rd_scalar_src,
  output logic                           wen, dren, dwen,
  output vdec_pkg::vfunct3_e             vfunct3,
  output vdec_pkg::cfgsel_e              cfgsel
);

  logic is_vec, width_ok, is_cfg;

  assign vs1       = instr.arith.vs1;
  assign vs2       = instr.arith.vs2;
  assign vd        = instr.arith.vd;
  assign vm        = instr.arith.vm;
  assign vfunct3   = instr.arith.funct3;
  assign nf        = instr.mem.nf;
  assign mop       = instr.mem.mop;
  assign mem_width = instr.mem.width;

  assign width_ok  = instr.mem.width inside {vdec_pkg::VW_8, vdec_pkg::VW_16, vdec_pkg::VW_32};
  assign is_vload  = (instr.mem.opcode == vdec_pkg::OPC_LOAD_FP) && width_ok;
  assign is_vstore = (instr.mem.opcode == vdec_pkg::OPC_STORE_FP) && width_ok;

  assign is_vec  = instr.arith.opcode == vdec_pkg::OPC_VECTOR;
  assign is_vopi = is_vec && (vfunct3 inside {vdec_pkg::OPIVV, vdec_pkg::OPIVX, vdec_pkg::OPIVI});
  assign is_vopm = is_vec && (vfunct3 inside {vdec_pkg::OPMVV, vdec_pkg::OPMVX});
  assign is_cfg  = is_vec && (vfunct3 == vdec_pkg::OPCFG);

  // bit 31 clear is vsetvli, bit 30 then splits vsetivli/vsetvl
  assign cfgsel = !is_cfg                ? vdec_pkg::NOT_CFG  :
                  !instr.arith.funct6[5] ? vdec_pkg::VSETVLI  :
                  instr.arith.funct6[4]  ? vdec_pkg::VSETIVLI : vdec_pkg::VSETVL;

  assign wen  = is_vload | is_vopi | is_vopm;
  assign dren = is_vload;
  assign dwen = is_vstore;

  assign imm_op         = is_vec && (vfunct3 inside {vdec_pkg::OPIVI, vdec_pkg::OPCFG});
  assign rs1_scalar_src = is_vload | is_vstore | is_cfg |
                          (is_vec && (vfunct3 inside {vdec_pkg::OPIVX, vdec_pkg::OPMVX}));
  assign rs2_scalar_src = (is_vload | is_vstore) && (mop == vdec_pkg::MOP_STRIDED);
  assign rd_scalar_src  = is_cfg;  // new vl goes to rd

endmodule

//--- hdl/vop_decode.sv
////////////////////////////////////////////////////////////
// funct6/funct3 lookup into vop_e
// an OPI/OPM word with an unknown funct6 or a form that
// RVV does not define gives OP_NONE and illegal
// config and memory words never raise illegal
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module vop_decode (
  input  logic [5:0]         funct6,
  input  vdec_pkg::vfunct3_e vfunct3,
  input  logic               is_vopi,
  input  logic               is_vopm,
  output vdec_pkg::vop_e     vop,
  output logic               illegal
);

  logic [8:0] sel;   // {candidate op, allowed forms}
  logic [2:0] form;
  logic       hit;

  always_comb begin
    sel = '0;
    if (is_vopi) begin
      case (vdec_pkg::vopi_f6_e'(funct6))
        vdec_pkg::VADD:   sel = {vdec_pkg::OP_VADD, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VSUB:   sel = {vdec_pkg::OP_VSUB, vdec_pkg::FM_VV_VX};
        vdec_pkg::VRSUB:  sel = {vdec_pkg::OP_VRSUB, vdec_pkg::FM_VX_VI};
        vdec_pkg::VMINU:  sel = {vdec_pkg::OP_VMINU, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMIN:   sel = {vdec_pkg::OP_VMIN, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMAXU:  sel = {vdec_pkg::OP_VMAXU, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMAX:   sel = {vdec_pkg::OP_VMAX, vdec_pkg::FM_VV_VX};
        vdec_pkg::VAND:   sel = {vdec_pkg::OP_VAND, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VOR:    sel = {vdec_pkg::OP_VOR, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VXOR:   sel = {vdec_pkg::OP_VXOR, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VADC:   sel = {vdec_pkg::OP_VADC, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VMADC:  sel = {vdec_pkg::OP_VMADC, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VSBC:   sel = {vdec_pkg::OP_VSBC, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMSBC:  sel = {vdec_pkg::OP_VMSBC, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMERGE: sel = {vdec_pkg::OP_VMERGE, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VMSEQ:  sel = {vdec_pkg::OP_VMSEQ, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VMSNE:  sel = {vdec_pkg::OP_VMSNE, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VMSLTU: sel = {vdec_pkg::OP_VMSLTU, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMSLT:  sel = {vdec_pkg::OP_VMSLT, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMSLEU: sel = {vdec_pkg::OP_VMSLEU, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VMSLE:  sel = {vdec_pkg::OP_VMSLE, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VMSGTU: sel = {vdec_pkg::OP_VMSGTU, vdec_pkg::FM_VX_VI};
        vdec_pkg::VMSGT:  sel = {vdec_pkg::OP_VMSGT, vdec_pkg::FM_VX_VI};
        vdec_pkg::VSLL:   sel = {vdec_pkg::OP_VSLL, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VSRL:   sel = {vdec_pkg::OP_VSRL, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VSRA:   sel = {vdec_pkg::OP_VSRA, vdec_pkg::FM_VV_VX_VI};
        vdec_pkg::VNSRL:  sel = {vdec_pkg::OP_VNSRL, vdec_pkg::FM_VV_VX_VI};  // wv form in vv slot
        vdec_pkg::VNSRA:  sel = {vdec_pkg::OP_VNSRA, vdec_pkg::FM_VV_VX_VI};
        default:          sel = '0;
      endcase
    end else if (is_vopm) begin
      case (vdec_pkg::vopm_f6_e'(funct6))
        vdec_pkg::VREDSUM:  sel = {vdec_pkg::OP_VREDSUM, vdec_pkg::FM_VV};
        vdec_pkg::VREDAND:  sel = {vdec_pkg::OP_VREDAND, vdec_pkg::FM_VV};
        vdec_pkg::VREDOR:   sel = {vdec_pkg::OP_VREDOR, vdec_pkg::FM_VV};
        vdec_pkg::VREDXOR:  sel = {vdec_pkg::OP_VREDXOR, vdec_pkg::FM_VV};
        vdec_pkg::VREDMINU: sel = {vdec_pkg::OP_VREDMINU, vdec_pkg::FM_VV};
        vdec_pkg::VREDMIN:  sel = {vdec_pkg::OP_VREDMIN, vdec_pkg::FM_VV};
        vdec_pkg::VREDMAXU: sel = {vdec_pkg::OP_VREDMAXU, vdec_pkg::FM_VV};
        vdec_pkg::VREDMAX:  sel = {vdec_pkg::OP_VREDMAX, vdec_pkg::FM_VV};
        vdec_pkg::VMANDN:   sel = {vdec_pkg::OP_VMANDN, vdec_pkg::FM_VV};
        vdec_pkg::VMAND:    sel = {vdec_pkg::OP_VMAND, vdec_pkg::FM_VV};
        vdec_pkg::VMOR:     sel = {vdec_pkg::OP_VMOR, vdec_pkg::FM_VV};
        vdec_pkg::VMXOR:    sel = {vdec_pkg::OP_VMXOR, vdec_pkg::FM_VV};
        vdec_pkg::VMORN:    sel = {vdec_pkg::OP_VMORN, vdec_pkg::FM_VV};
        vdec_pkg::VMNAND:   sel = {vdec_pkg::OP_VMNAND, vdec_pkg::FM_VV};
        vdec_pkg::VMNOR:    sel = {vdec_pkg::OP_VMNOR, vdec_pkg::FM_VV};
        vdec_pkg::VMXNOR:   sel = {vdec_pkg::OP_VMXNOR, vdec_pkg::FM_VV};
        vdec_pkg::VDIVU:    sel = {vdec_pkg::OP_VDIVU, vdec_pkg::FM_VV_VX};
        vdec_pkg::VDIV:     sel = {vdec_pkg::OP_VDIV, vdec_pkg::FM_VV_VX};
        vdec_pkg::VREMU:    sel = {vdec_pkg::OP_VREMU, vdec_pkg::FM_VV_VX};
        vdec_pkg::VREM:     sel = {vdec_pkg::OP_VREM, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMULHU:   sel = {vdec_pkg::OP_VMULHU, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMUL:     sel = {vdec_pkg::OP_VMUL, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMULHSU:  sel = {vdec_pkg::OP_VMULHSU, vdec_pkg::FM_VV_VX};
        vdec_pkg::VMULH:    sel = {vdec_pkg::OP_VMULH, vdec_pkg::FM_VV_VX};
        default:            sel = '0;
      endcase
    end
  end

  // one-hot form of this word, OPM shares the vv/vx bits
  always_comb begin
    case (vfunct3)
      vdec_pkg::OPIVV, vdec_pkg::OPMVV: form = 3'b001;
      vdec_pkg::OPIVX, vdec_pkg::OPMVX: form = 3'b010;
      vdec_pkg::OPIVI:                  form = 3'b100;
      default:                          form = 3'b000;
    endcase
  end

  assign hit     = |(sel[2:0] & form);
  assign vop     = hit ? vdec_pkg::vop_e'(sel[8:3]) : vdec_pkg::OP_NONE;
  assign illegal = (is_vopi | is_vopm) & ~hit;

endmodule

//--- hdl/vunit_select.sv
////////////////////////////////////////////////////////////
// unit and ALU control from the decoded op
// relies on the group ordering of vop_e
// loads and stores go to FU_LDST whatever vop holds
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module vunit_select (
  input  vdec_pkg::vop_e    vop,
  input  logic              is_vload,
  input  logic              is_vstore,
  output vdec_pkg::fu_e     fu_type,
  output vdec_pkg::aluop_e  aluop,
  output vdec_pkg::comp_e   comp_type,
  output vdec_pkg::minmax_e minmax_type,
  output vdec_pkg::result_e result_type,
  output logic              is_signed,
  output logic              single_bit_op
);

  logic [5:0] cmp_idx;  // position inside the compare block

  assign cmp_idx       = vop - vdec_pkg::OP_VMSEQ;
  assign single_bit_op = vop inside {[vdec_pkg::OP_VMSEQ:vdec_pkg::OP_VMSGT]};
  assign is_signed     = !(vop inside {[vdec_pkg::OP_VSLL:vdec_pkg::OP_VNSRA]});  // uimm shamt
  assign comp_type     = single_bit_op ? vdec_pkg::comp_e'(cmp_idx[2:0]) : vdec_pkg::VSEQ;

  always_comb begin
    fu_type     = vdec_pkg::FU_ARITH;
    result_type = vdec_pkg::NORMAL;
    case (vop) inside
      vdec_pkg::OP_VMADC, vdec_pkg::OP_VMSBC:      result_type = vdec_pkg::CARRY;
      [vdec_pkg::OP_VREDSUM:vdec_pkg::OP_VREDMAX]: fu_type = vdec_pkg::FU_RED;
      [vdec_pkg::OP_VMANDN:vdec_pkg::OP_VMXNOR]:   fu_type = vdec_pkg::FU_MASK;
      [vdec_pkg::OP_VDIVU:vdec_pkg::OP_VREM]: begin
        fu_type     = vdec_pkg::FU_DIV;
        result_type = (vop inside {vdec_pkg::OP_VREMU, vdec_pkg::OP_VREM}) ?
                      vdec_pkg::REM : vdec_pkg::DIV;
      end
      [vdec_pkg::OP_VMULHU:vdec_pkg::OP_VMULH]: begin
        fu_type     = vdec_pkg::FU_MUL;
        result_type = vdec_pkg::MULT;
      end
      default: ;
    endcase
    if (is_vload || is_vstore)
      fu_type = vdec_pkg::FU_LDST;
  end

  always_comb begin
    case (vop) inside
      vdec_pkg::OP_VSUB, vdec_pkg::OP_VRSUB, vdec_pkg::OP_VSBC, vdec_pkg::OP_VMSBC:
        aluop = vdec_pkg::VALU_SUB;
      vdec_pkg::OP_VAND, vdec_pkg::OP_VREDAND, vdec_pkg::OP_VMANDN, vdec_pkg::OP_VMAND,
      vdec_pkg::OP_VMNAND:
        aluop = vdec_pkg::VALU_AND;
      vdec_pkg::OP_VOR, vdec_pkg::OP_VREDOR, vdec_pkg::OP_VMOR, vdec_pkg::OP_VMORN,
      vdec_pkg::OP_VMNOR:
        aluop = vdec_pkg::VALU_OR;
      vdec_pkg::OP_VXOR, vdec_pkg::OP_VREDXOR, vdec_pkg::OP_VMXOR, vdec_pkg::OP_VMXNOR:
        aluop = vdec_pkg::VALU_XOR;
      vdec_pkg::OP_VSLL:                     aluop = vdec_pkg::VALU_SLL;
      vdec_pkg::OP_VSRL, vdec_pkg::OP_VNSRL: aluop = vdec_pkg::VALU_SRL;
      vdec_pkg::OP_VSRA, vdec_pkg::OP_VNSRA: aluop = vdec_pkg::VALU_SRA;
      [vdec_pkg::OP_VMSEQ:vdec_pkg::OP_VMSGT]: aluop = vdec_pkg::VALU_COMP;
      vdec_pkg::OP_VMERGE:                     aluop = vdec_pkg::VALU_MERGE;
      [vdec_pkg::OP_VMINU:vdec_pkg::OP_VMAX], [vdec_pkg::OP_VREDMINU:vdec_pkg::OP_VREDMAX]:
        aluop = vdec_pkg::VALU_MM;
      default: aluop = vdec_pkg::VALU_ADD;  // add, adc, madc, redsum, mul/div
    endcase
  end

  always_comb begin
    case (vop)
      vdec_pkg::OP_VMINU, vdec_pkg::OP_VREDMINU: minmax_type = vdec_pkg::MINU;
      vdec_pkg::OP_VMAX, vdec_pkg::OP_VREDMAX:   minmax_type = vdec_pkg::MAX;
      vdec_pkg::OP_VMAXU, vdec_pkg::OP_VREDMAXU: minmax_type = vdec_pkg::MAXU;
      default:                                   minmax_type = vdec_pkg::MIN;
    endcase
  end

endmodule

//--- hdl/vdecode_latch.sv
////////////////////////////////////////////////////////////
// decode to execute register, one cycle of latency
// dec_valid follows instr_valid, the rest holds when idle
// register fields and memory fields come out of reset unknown
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module vdecode_latch (
  input  logic                           CLK,
  input  logic                           rst_n,
  input  logic                           instr_valid,
  input  logic [vdec_pkg::REG_IDX_W-1:0] vs1, vs2, vd,
  input  logic [2:0]                     nf, mem_width,
  input  logic [1:0]                     mop,
  input  logic                           vm, is_vload, is_vstore, is_vopi, is_vopm, imm_op,
  input  logic                           rs1_scalar_src, rs2_scalar_src, rd_scalar_src,
  input  logic                           wen, dren, dwen, illegal, is_signed, single_bit_op,
  input  vdec_pkg::vfunct3_e             vfunct3,
  input  vdec_pkg::cfgsel_e              cfgsel,
  input  vdec_pkg::vop_e                 vop,
  input  vdec_pkg::fu_e                  fu_type,
  input  vdec_pkg::aluop_e               aluop,
  input  vdec_pkg::comp_e                comp_type,
  input  vdec_pkg::minmax_e              minmax_type,
  input  vdec_pkg::result_e              result_type,
  output logic                           dec_valid,
  output logic [vdec_pkg::REG_IDX_W-1:0] dec_vs1, dec_vs2, dec_vd,
  output logic [2:0]                     dec_nf, dec_mem_width,
  output logic [1:0]                     dec_mop,
  output logic                           dec_vm, dec_is_vload, dec_is_vstore,
  output logic                           dec_is_vopi, dec_is_vopm, dec_imm_op,
  output logic                           dec_rs1_scalar_src, dec_rs2_scalar_src,
  output logic                           dec_rd_scalar_src, dec_wen, dec_dren, dec_dwen,
  output logic                           dec_illegal, dec_is_signed, dec_single_bit_op,
  output vdec_pkg::vfunct3_e             dec_vfunct3,
  output vdec_pkg::cfgsel_e              dec_cfgsel,
  output vdec_pkg::vop_e                 dec_vop,
  output vdec_pkg::fu_e                  dec_fu_type,
  output vdec_pkg::aluop_e               dec_aluop,
  output vdec_pkg::comp_e                dec_comp_type,
  output vdec_pkg::minmax_e              dec_minmax_type,
  output vdec_pkg::result_e              dec_result_type
);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
      {dec_wen, dec_dren, dec_dwen, dec_illegal, dec_imm_op} <= '0;
      {dec_is_vload, dec_is_vstore, dec_is_vopi, dec_is_vopm} <= '0;
      {dec_rs1_scalar_src, dec_rs2_scalar_src, dec_rd_scalar_src} <= '0;
      {dec_is_signed, dec_single_bit_op} <= '0;
      dec_vfunct3     <= vdec_pkg::OPIVV;
      dec_cfgsel      <= vdec_pkg::NOT_CFG;
      dec_vop         <= vdec_pkg::OP_NONE;
      dec_fu_type     <= vdec_pkg::FU_ARITH;
      dec_aluop       <= vdec_pkg::VALU_ADD;
      dec_comp_type   <= vdec_pkg::VSEQ;
      dec_minmax_type <= vdec_pkg::MIN;
      dec_result_type <= vdec_pkg::NORMAL;
    end else begin
      dec_valid <= instr_valid;
      if (instr_valid) begin
        {dec_wen, dec_dren, dec_dwen, dec_illegal, dec_imm_op} <=
          {wen, dren, dwen, illegal, imm_op};
        {dec_is_vload, dec_is_vstore, dec_is_vopi, dec_is_vopm} <=
          {is_vload, is_vstore, is_vopi, is_vopm};
        {dec_rs1_scalar_src, dec_rs2_scalar_src, dec_rd_scalar_src} <=
          {rs1_scalar_src, rs2_scalar_src, rd_scalar_src};
        {dec_is_signed, dec_single_bit_op} <= {is_signed, single_bit_op};
        dec_vfunct3     <= vfunct3;
        dec_cfgsel      <= cfgsel;
        dec_vop         <= vop;
        dec_fu_type     <= fu_type;
        dec_aluop       <= aluop;
        dec_comp_type   <= comp_type;
        dec_minmax_type <= minmax_type;
        dec_result_type <= result_type;
      end
    end
  end

  // operand fields, no reset
  always_ff @(posedge CLK) begin
    if (instr_valid) begin
      {dec_vs1, dec_vs2, dec_vd, dec_vm} <= {vs1, vs2, vd, vm};
      {dec_nf, dec_mop, dec_mem_width}   <= {nf, mop, mem_width};
    end
  end

endmodule

//--- hdl/vector_control_unit.sv
////////////////////////////////////////////////////////////
// RVV decode stage top, one word per cycle
// control word is valid one cycle after instr_valid
// no back-pressure, execute takes every valid word
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module vector_control_unit (
  input  logic                           CLK,
  input  logic                           rst_n,
  input  logic                           instr_valid,
  input  logic [vdec_pkg::INSTR_W-1:0]   instr,
  output logic                           dec_valid,
  output logic [vdec_pkg::REG_IDX_W-1:0] dec_vs1, dec_vs2, dec_vd,
  output logic [2:0]                     dec_nf, dec_mem_width,
  output logic [1:0]                     dec_mop,
  output logic                           dec_vm, dec_is_vload, dec_is_vstore,
  output logic                           dec_is_vopi, dec_is_vopm, dec_imm_op,
  output logic                           dec_rs1_scalar_src, dec_rs2_scalar_src,
  output logic                           dec_rd_scalar_src, dec_wen, dec_dren, dec_dwen,
  output logic                           dec_illegal, dec_is_signed, dec_single_bit_op,
  output vdec_pkg::vfunct3_e             dec_vfunct3,
  output vdec_pkg::cfgsel_e              dec_cfgsel,
  output vdec_pkg::vop_e                 dec_vop,
  output vdec_pkg::fu_e                  dec_fu_type,
  output vdec_pkg::aluop_e               dec_aluop,
  output vdec_pkg::comp_e                dec_comp_type,
  output vdec_pkg::minmax_e              dec_minmax_type,
  output vdec_pkg::result_e              dec_result_type
);

  logic [vdec_pkg::REG_IDX_W-1:0] vs1, vs2, vd;
  logic [2:0]                     nf, mem_width;
  logic [1:0]                     mop;
  logic                           vm, is_vload, is_vstore, is_vopi, is_vopm, imm_op;
  logic                           rs1_scalar_src, rs2_scalar_src, rd_scalar_src;
  logic                           wen, dren, dwen, illegal, is_signed, single_bit_op;
  vdec_pkg::vfunct3_e             vfunct3;
  vdec_pkg::cfgsel_e              cfgsel;
  vdec_pkg::vop_e                 vop;
  vdec_pkg::fu_e                  fu_type;
  vdec_pkg::aluop_e               aluop;
  vdec_pkg::comp_e                comp_type;
  vdec_pkg::minmax_e              minmax_type;
  vdec_pkg::result_e              result_type;

  vfield_decode u_field (.instr(instr), .*);

  vop_decode u_op (.funct6(instr[31:26]), .*);  // funct6 sits at the top of the word

  vunit_select u_unit (.*);

  vdecode_latch u_latch (.*);

endmodule

//--- sim/vcu_tb.sv
////////////////////////////////////////////////////////////
// directed testbench for the RVV decode stage
// inputs change on the falling edge, outputs are checked
// one cycle after each word, words issue back to back
// stops at the first mismatch, watchdog bounds the run
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module vcu_tb;

  localparam int PERIOD     = 8;
  localparam int RST_CYCLES = 4;
  localparam int N_WORDS    = 30;  // words issued over all tests, idle slots included
  localparam int TIMEOUT_NS = (RST_CYCLES + N_WORDS + 20) * PERIOD;

  logic                           CLK, rst_n, instr_valid;
  logic [vdec_pkg::INSTR_W-1:0]   instr;
  logic                           dec_valid;
  logic [vdec_pkg::REG_IDX_W-1:0] dec_vs1, dec_vs2, dec_vd;
  logic [2:0]                     dec_nf, dec_mem_width;
  logic [1:0]                     dec_mop;
  logic                           dec_vm, dec_is_vload, dec_is_vstore;
  logic                           dec_is_vopi, dec_is_vopm, dec_imm_op;
  logic                           dec_rs1_scalar_src, dec_rs2_scalar_src;
  logic                           dec_rd_scalar_src, dec_wen, dec_dren, dec_dwen;
  logic                           dec_illegal, dec_is_signed, dec_single_bit_op;
  vdec_pkg::vfunct3_e             dec_vfunct3;
  vdec_pkg::cfgsel_e              dec_cfgsel;
  vdec_pkg::vop_e                 dec_vop;
  vdec_pkg::fu_e                  dec_fu_type;
  vdec_pkg::aluop_e               dec_aluop;
  vdec_pkg::comp_e                dec_comp_type;
  vdec_pkg::minmax_e              dec_minmax_type;
  vdec_pkg::result_e              dec_result_type;

  logic [31:0] rng_state = 32'h8361749d;

  vector_control_unit i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the decode tests did not finish in time");
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Some tests failed");
      $fatal(1, "check failed");
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] seed);
    logic [31:0] x;
    x = seed;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic pick_regs(output logic [4:0] rd, output logic [4:0] r1, output logic [4:0] r2);
    rng_state = xorshift32(rng_state);
    rd = rng_state[4:0];
    r1 = rng_state[12:8];
    r2 = rng_state[20:16];
  endtask

  // arithmetic and config format, vm set
  function automatic logic [31:0] arith_word(input logic [5:0] f6, input logic [2:0] f3,
                                             input logic [4:0] vd, input logic [4:0] vs1,
                                             input logic [4:0] vs2);
    return {f6, 1'b1, vs2, vs1, f3, vd, vdec_pkg::OPC_VECTOR};
  endfunction

  // memory format, vm clear
  function automatic logic [31:0] mem_word(input logic [2:0] nf, input logic [2:0] width,
                                           input logic [1:0] mop, input logic [4:0] rs1,
                                           input logic [4:0] vd, input logic [6:0] opcode);
    return {nf, 1'b0, mop, 1'b0, 5'b00000, rs1, width, vd, opcode};
  endfunction

  // called on a falling edge, returns one cycle later with the word registered
  task automatic issue_word(input logic [31:0] word, input logic valid);
    instr_valid = valid;
    instr       = word;
    @(negedge CLK);
  endtask

  task automatic reset_test;
    issue_word('0, 1'b0);
    check_eq("dec_valid", dec_valid, 0);
    check_eq("dec_wen", dec_wen, 0);
    check_eq("dec_dren", dec_dren, 0);
    check_eq("dec_dwen", dec_dwen, 0);
    check_eq("dec_illegal", dec_illegal, 0);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_NONE);
    check_eq("dec_cfgsel", dec_cfgsel, vdec_pkg::NOT_CFG);
    issue_word(arith_word(6'b000000, vdec_pkg::OPIVV, 5'd1, 5'd2, 5'd3), 1'b1);
    check_eq("dec_valid", dec_valid, 1);
    issue_word('0, 1'b0);
    check_eq("dec_valid", dec_valid, 0);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_VADD);  // held while idle
  endtask

  task automatic opi_arith_test;
    logic [4:0] rd, r1, r2;
    pick_regs(rd, r1, r2);
    issue_word(arith_word(6'b000000, vdec_pkg::OPIVV, rd, r1, r2), 1'b1);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_VADD);
    check_eq("dec_fu_type", dec_fu_type, vdec_pkg::FU_ARITH);
    check_eq("dec_aluop", dec_aluop, vdec_pkg::VALU_ADD);
    check_eq("dec_wen", dec_wen, 1);
    check_eq("dec_imm_op", dec_imm_op, 0);
    check_eq("dec_is_vopi", dec_is_vopi, 1);
    check_eq("dec_is_vopm", dec_is_vopm, 0);
    check_eq("dec_vfunct3", dec_vfunct3, vdec_pkg::OPIVV);
    check_eq("dec_vm", dec_vm, 1);
    check_eq("dec_vd", dec_vd, rd);
    check_eq("dec_vs1", dec_vs1, r1);
    check_eq("dec_vs2", dec_vs2, r2);
    pick_regs(rd, r1, r2);
    issue_word(arith_word(6'b000000, vdec_pkg::OPIVI, rd, r1, r2), 1'b1);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_VADD);
    check_eq("dec_imm_op", dec_imm_op, 1);
    check_eq("dec_is_signed", dec_is_signed, 1);
    check_eq("dec_vd", dec_vd, rd);
    pick_regs(rd, r1, r2);
    issue_word(arith_word(6'b100101, vdec_pkg::OPIVI, rd, r1, r2), 1'b1);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_VSLL);
    check_eq("dec_aluop", dec_aluop, vdec_pkg::VALU_SLL);
    check_eq("dec_is_signed", dec_is_signed, 0);
    check_eq("dec_vs2", dec_vs2, r2);
    issue_word(arith_word(6'b000110, vdec_pkg::OPIVX, 5'd1, 5'd2, 5'd3), 1'b1);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_VMAXU);
    check_eq("dec_aluop", dec_aluop, vdec_pkg::VALU_MM);
    check_eq("dec_minmax_type", dec_minmax_type, vdec_pkg::MAXU);
  endtask

  task automatic illegal_case(input logic [5:0] f6, input logic [2:0] f3);
    issue_word(arith_word(f6, f3, 5'd4, 5'd5, 5'd6), 1'b1);
    check_eq("dec_illegal", dec_illegal, 1);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_NONE);
  endtask

  task automatic legality_test;
    illegal_case(6'b000010, vdec_pkg::OPIVI);  // vsub has no vi form
    illegal_case(6'b000000, vdec_pkg::OPMVX);  // reductions are vv only
    illegal_case(6'b001000, vdec_pkg::OPIVV);
  endtask

  task automatic compare_case(input logic [5:0] f6, input logic [2:0] f3,
                              input vdec_pkg::vop_e exp_vop, input vdec_pkg::comp_e exp_cmp);
    issue_word(arith_word(f6, f3, 5'd7, 5'd8, 5'd9), 1'b1);
    check_eq("dec_vop", dec_vop, exp_vop);
    check_eq("dec_single_bit_op", dec_single_bit_op, 1);
    check_eq("dec_aluop", dec_aluop, vdec_pkg::VALU_COMP);
    check_eq("dec_comp_type", dec_comp_type, exp_cmp);
    check_eq("dec_illegal", dec_illegal, 0);
  endtask

  task automatic compare_test;
    compare_case(6'b011000, vdec_pkg::OPIVV, vdec_pkg::OP_VMSEQ, vdec_pkg::VSEQ);
    compare_case(6'b011001, vdec_pkg::OPIVX, vdec_pkg::OP_VMSNE, vdec_pkg::VSNE);
    compare_case(6'b011010, vdec_pkg::OPIVV, vdec_pkg::OP_VMSLTU, vdec_pkg::VSLTU);
    compare_case(6'b011011, vdec_pkg::OPIVX, vdec_pkg::OP_VMSLT, vdec_pkg::VSLT);
    compare_case(6'b011100, vdec_pkg::OPIVI, vdec_pkg::OP_VMSLEU, vdec_pkg::VSLEU);
    compare_case(6'b011101, vdec_pkg::OPIVV, vdec_pkg::OP_VMSLE, vdec_pkg::VSLE);
    compare_case(6'b011110, vdec_pkg::OPIVX, vdec_pkg::OP_VMSGTU, vdec_pkg::VSGTU);
    compare_case(6'b011111, vdec_pkg::OPIVI, vdec_pkg::OP_VMSGT, vdec_pkg::VSGT);
  endtask

  task automatic opm_test;
    issue_word(arith_word(6'b000000, vdec_pkg::OPMVV, 5'd1, 5'd2, 5'd3), 1'b1);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_VREDSUM);
    check_eq("dec_fu_type", dec_fu_type, vdec_pkg::FU_RED);
    check_eq("dec_is_vopm", dec_is_vopm, 1);
    check_eq("dec_is_vopi", dec_is_vopi, 0);
    check_eq("dec_vfunct3", dec_vfunct3, vdec_pkg::OPMVV);
    issue_word(arith_word(6'b100101, vdec_pkg::OPMVV, 5'd1, 5'd2, 5'd3), 1'b1);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_VMUL);
    check_eq("dec_fu_type", dec_fu_type, vdec_pkg::FU_MUL);
    check_eq("dec_result_type", dec_result_type, vdec_pkg::MULT);
    issue_word(arith_word(6'b100011, vdec_pkg::OPMVX, 5'd1, 5'd2, 5'd3), 1'b1);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_VREM);
    check_eq("dec_fu_type", dec_fu_type, vdec_pkg::FU_DIV);
    check_eq("dec_result_type", dec_result_type, vdec_pkg::REM);
    check_eq("dec_rs1_scalar_src", dec_rs1_scalar_src, 1);
    issue_word(arith_word(6'b011001, vdec_pkg::OPMVV, 5'd1, 5'd2, 5'd3), 1'b1);
    check_eq("dec_vop", dec_vop, vdec_pkg::OP_VMAND);
    check_eq("dec_fu_type", dec_fu_type, vdec_pkg::FU_MASK);
  endtask

  task automatic load_case(input logic [2:0] width, input logic [1:0] mop);
    issue_word(mem_word(3'd0, width, mop, 5'd10, 5'd11, vdec_pkg::OPC_LOAD_FP), 1'b1);
    check_eq("dec_is_vload", dec_is_vload, 1);
    check_eq("dec_dren", dec_dren, 1);
    check_eq("dec_wen", dec_wen, 1);
    check_eq("dec_dwen", dec_dwen, 0);
    check_eq("dec_fu_type", dec_fu_type, vdec_pkg::FU_LDST);
    check_eq("dec_mem_width", dec_mem_width, width);
    check_eq("dec_mop", dec_mop, mop);
    check_eq("dec_vm", dec_vm, 0);
    check_eq("dec_rs1_scalar_src", dec_rs1_scalar_src, 1);
    check_eq("dec_rs2_scalar_src", dec_rs2_scalar_src, mop == 2'd2);
  endtask

  task automatic cfg_case(input logic [5:0] f6, input vdec_pkg::cfgsel_e exp_cfg);
    issue_word(arith_word(f6, vdec_pkg::OPCFG, 5'd12, 5'd13, 5'd0), 1'b1);
    check_eq("dec_cfgsel", dec_cfgsel, exp_cfg);
    check_eq("dec_rd_scalar_src", dec_rd_scalar_src, 1);
    check_eq("dec_illegal", dec_illegal, 0);
    check_eq("dec_wen", dec_wen, 0);
  endtask

  task automatic mem_cfg_test;
    load_case(vdec_pkg::VW_8, 2'd0);
    load_case(vdec_pkg::VW_16, 2'd0);
    load_case(vdec_pkg::VW_32, 2'd0);
    load_case(vdec_pkg::VW_32, 2'd2);  // strided, stride from rs2
    issue_word(mem_word(3'd3, vdec_pkg::VW_16, 2'd0, 5'd14, 5'd15, vdec_pkg::OPC_STORE_FP),
               1'b1);
    check_eq("dec_is_vstore", dec_is_vstore, 1);
    check_eq("dec_dwen", dec_dwen, 1);
    check_eq("dec_wen", dec_wen, 0);
    check_eq("dec_dren", dec_dren, 0);
    check_eq("dec_nf", dec_nf, 3);
    check_eq("dec_fu_type", dec_fu_type, vdec_pkg::FU_LDST);
    cfg_case(6'b000000, vdec_pkg::VSETVLI);
    cfg_case(6'b110000, vdec_pkg::VSETIVLI);
    cfg_case(6'b100000, vdec_pkg::VSETVL);
  endtask

  initial begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    reset_test();
    opi_arith_test();
    legality_test();
    compare_test();
    opm_test();
    mem_cfg_test();
    $display("All tests passed");
    $finish;
  end

endmodule

//--- build.f
hdl/vdec_pkg.sv
hdl/vfield_decode.sv
hdl/vop_decode.sv
hdl/vunit_select.sv
hdl/vdecode_latch.sv
hdl/vector_control_unit.sv
sim/vcu_tb.sv

//--- Bender.yml
package:
  name: vector_control_unit

sources:
  - hdl/vdec_pkg.sv
  - hdl/vfield_decode.sv
  - hdl/vop_decode.sv
  - hdl/vunit_select.sv
  - hdl/vdecode_latch.sv
  - hdl/vector_control_unit.sv
  - target: simulation
    files:
      - sim/vcu_tb.sv
